//--- eth_arp_settings.svh
// ARP responder settings
`ifndef ETH_ARP_SETTINGS_SVH
`define ETH_ARP_SETTINGS_SVH

// board identity
`define BOARD_MAC_ADDR 48'h00_11_22_33_44_55
`define BOARD_IP_ADDR 32'hA9_FE_01_17 // 169.254.1.23

// frame layout
`define PREAMBLE_LEN 7
`define ARP_FILL_LEN 18

// line symbols
`define PREAMBLE_BYTE 8'h55
`define SFD_BYTE 8'hD5

// protocol words
`define ETH_TYPE_ARP 16'h0806
`define ARP_HDR_IPV4 48'h0001_0800_0604 // ethernet, ipv4, hlen 6, plen 4
`define ARP_OP_REQUEST 16'h0001
`define ARP_OP_REPLY 16'h0002

`endif

//--- eth_arp_pkg.sv
// ARP responder types
`include "eth_arp_settings.svh"

package eth_arp_pkg;

	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;

	typedef struct packed {
		mac_addr_t mac;
		ip_addr_t ip;
	} arp_peer_t;

	typedef struct packed {
		logic dv;
		logic [7:0] data;
	} gmii_rx_t;

	// frame sections in wire order
	typedef enum logic [3:0] {
		IDLE, PREAMBLE, SFD, MAC_DES, MAC_SRC, ETH_TYPE, ARP_HDR, ARP_OP,
		ARP_SRC_MAC, ARP_SRC_IP, ARP_DES_MAC, ARP_DES_IP, ARP_FILL, FCS
	} arp_field_e;

	function automatic logic [4:0] field_len(input arp_field_e f);
		case (f)
			PREAMBLE: return 5'(`PREAMBLE_LEN);
			MAC_DES, MAC_SRC, ARP_HDR, ARP_SRC_MAC, ARP_DES_MAC: return 5'd6;
			ETH_TYPE, ARP_OP: return 5'd2;
			ARP_SRC_IP, ARP_DES_IP, FCS: return 5'd4;
			ARP_FILL: return 5'(`ARP_FILL_LEN);
			default: return 5'd1; // idle and sfd
		endcase
	endfunction

endpackage

//--- crc32_d8.sv
// byte-wide CRC-32
`timescale 1ns/1ps

module crc32_d8 (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic [7:0] data,
	input logic start,
	input logic en,
	output logic [31:0] fcs,
	output logic [31:0] fcs_next
);

	localparam logic [31:0] POLY = 32'hEDB8_8320; // reflected 04C11DB7

	logic [31:0] crc_q;
	logic [31:0] crc_base;
	logic [31:0] crc_d;

	// one byte, lsb first
	function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c ^ {24'h0, d};
		for (int i = 0; i < 8; i++) begin
			if (r[0]) begin
				r = (r >> 1) ^ POLY;
			end else begin
				r = r >> 1;
			end
		end
		return r;
	endfunction

	assign crc_base = start ? 32'hFFFF_FFFF : crc_q; // seed before the first byte
	assign crc_d = en ? crc_step(crc_base, data) : crc_base;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			crc_q <= 32'hFFFF_FFFF;
		end else begin
			crc_q <= crc_d;
		end
	end

	// finished FCS is the inverted register
	assign fcs = ~crc_q;
	assign fcs_next = ~crc_d;

endmodule

//--- arp_rx_parser.sv
// ARP request receiver
`timescale 1ns/1ps
`include "eth_arp_settings.svh"

module arp_rx_parser (
	input logic sys_clk,
	input logic sys_rst_n,
	input eth_arp_pkg::gmii_rx_t rx,
	output eth_arp_pkg::arp_peer_t peer,
	output logic peer_refresh
);

	import eth_arp_pkg::*;

	arp_field_e field;
	logic [4:0] idx;
	logic last;
	logic bad;
	logic [47:0] asm_q;
	logic [47:0] asm_d;
	arp_peer_t pending;
	logic crc_start;
	logic crc_en;
	logic [31:0] crc_fcs;
	logic [31:0] rx_fcs;
	logic fcs_end;
	logic req_ok;

	assign asm_d = {asm_q[39:0], rx.data}; // field value including this byte
	assign last = (idx == field_len(field) - 5'd1);

	// field checks, applied when the field completes
	always_comb begin
		bad = 1'b0;
		case (field)
			PREAMBLE: bad = (rx.data != `PREAMBLE_BYTE);
			SFD: bad = (rx.data != `SFD_BYTE);
			MAC_DES: bad = last && (asm_d != 48'hFFFF_FFFF_FFFF) && (asm_d != `BOARD_MAC_ADDR);
			ETH_TYPE: bad = last && (asm_d[15:0] != `ETH_TYPE_ARP);
			ARP_HDR: bad = last && (asm_d != `ARP_HDR_IPV4);
			ARP_OP: bad = last && (asm_d[15:0] != `ARP_OP_REQUEST);
			ARP_DES_IP: bad = last && (asm_d[31:0] != `BOARD_IP_ADDR);
			default: bad = 1'b0;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			field <= IDLE;
			idx <= '0;
		end else if (rx.dv) begin
			if (field == IDLE) begin
				if (rx.data == `PREAMBLE_BYTE) begin
					field <= PREAMBLE;
					idx <= 5'd1; // first preamble byte already seen
				end
			end else if (bad) begin
				field <= IDLE;
				idx <= '0;
			end else if (last) begin
				field <= (field == FCS) ? IDLE : arp_field_e'(field + 4'd1);
				idx <= '0;
			end else begin
				idx <= idx + 5'd1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rx.dv) begin
			asm_q <= asm_d;
		end
	end

	// requester identity, kept until the FCS decides
	always_ff @(posedge sys_clk) begin
		if (rx.dv && last && field == MAC_SRC) begin
			pending.mac <= asm_d;
		end
		if (rx.dv && last && field == ARP_SRC_IP) begin
			pending.ip <= asm_d[31:0];
		end
	end

	// CRC covers destination MAC through the last fill byte
	assign crc_start = rx.dv && (field == MAC_DES) && (idx == 5'd0);
	assign crc_en = rx.dv && (field >= MAC_DES) && (field <= ARP_FILL);

	crc32_d8 u_crc (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.data(rx.data),
		.start(crc_start),
		.en(crc_en),
		.fcs(crc_fcs),
		.fcs_next()
	);

	// FCS arrives lsb first, so the oldest byte is the low one
	assign rx_fcs = {asm_q[7:0], asm_q[15:8], asm_q[23:16], asm_q[31:24]};

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			fcs_end <= 1'b0;
			req_ok <= 1'b0;
		end else begin
			fcs_end <= rx.dv && (field == FCS) && last;
			req_ok <= fcs_end && (rx_fcs == crc_fcs);
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			peer <= '0;
			peer_refresh <= 1'b0;
		end else begin
			peer_refresh <= req_ok;
			if (req_ok) begin
				peer <= pending;
			end
		end
	end

endmodule

//--- arp_tx_framer.sv
// ARP reply transmitter
`timescale 1ns/1ps
`include "eth_arp_settings.svh"

module arp_tx_framer (
	input logic sys_clk,
	input logic sys_rst_n,
	input eth_arp_pkg::arp_peer_t peer,
	input logic peer_refresh,
	input logic gmii_txbusy,
	output logic gmii_txen,
	output logic [7:0] gmii_txdata
);

	import eth_arp_pkg::*;

	arp_field_e field;
	arp_field_e nxt_field;
	logic [4:0] idx;
	logic [4:0] nxt_idx;
	logic [7:0] nxt_byte;
	logic accept;
	arp_peer_t peer_q;
	logic crc_start;
	logic crc_en;
	logic [31:0] crc_fcs_next;

	// byte i of a big-endian word of len bytes
	function automatic logic [7:0] be_byte(input logic [47:0] w, input logic [4:0] len,
			input logic [4:0] i);
		return w[8 * (len - 5'd1 - i) +: 8];
	endfunction

	assign accept = gmii_txen && !gmii_txbusy;

	// position of the byte to present after this edge
	always_comb begin
		nxt_field = field;
		nxt_idx = idx;
		if (field == IDLE) begin
			if (peer_refresh) begin
				nxt_field = PREAMBLE;
				nxt_idx = '0;
			end
		end else if (accept) begin
			if (idx == field_len(field) - 5'd1) begin
				nxt_field = (field == FCS) ? IDLE : arp_field_e'(field + 4'd1);
				nxt_idx = '0;
			end else begin
				nxt_idx = idx + 5'd1;
			end
		end
	end

	always_comb begin
		case (nxt_field)
			PREAMBLE: nxt_byte = `PREAMBLE_BYTE;
			SFD: nxt_byte = `SFD_BYTE;
			MAC_DES, ARP_DES_MAC: nxt_byte = be_byte(peer_q.mac, 5'd6, nxt_idx);
			MAC_SRC, ARP_SRC_MAC: nxt_byte = be_byte(`BOARD_MAC_ADDR, 5'd6, nxt_idx);
			ETH_TYPE: nxt_byte = be_byte(48'(`ETH_TYPE_ARP), 5'd2, nxt_idx);
			ARP_HDR: nxt_byte = be_byte(`ARP_HDR_IPV4, 5'd6, nxt_idx);
			ARP_OP: nxt_byte = be_byte(48'(`ARP_OP_REPLY), 5'd2, nxt_idx);
			ARP_SRC_IP: nxt_byte = be_byte(48'(`BOARD_IP_ADDR), 5'd4, nxt_idx);
			ARP_DES_IP: nxt_byte = be_byte(48'(peer_q.ip), 5'd4, nxt_idx);
			FCS: nxt_byte = crc_fcs_next[8 * nxt_idx[1:0] +: 8]; // lsb first
			default: nxt_byte = 8'h00; // idle and zero fill
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			field <= IDLE;
			idx <= '0;
			gmii_txen <= 1'b0;
			gmii_txdata <= 8'h00;
		end else begin
			field <= nxt_field;
			idx <= nxt_idx;
			gmii_txen <= (nxt_field != IDLE);
			gmii_txdata <= nxt_byte; // same position while busy, so data holds
		end
	end

	// a refresh during a reply is dropped
	always_ff @(posedge sys_clk) begin
		if (field == IDLE && peer_refresh) begin
			peer_q <= peer;
		end
	end

	assign crc_start = accept && (field == MAC_DES) && (idx == 5'd0);
	assign crc_en = accept && (field >= MAC_DES) && (field <= ARP_FILL);

	// fcs_next lets the first FCS byte follow the last fill byte directly
	crc32_d8 u_crc (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.data(gmii_txdata),
		.start(crc_start),
		.en(crc_en),
		.fcs(),
		.fcs_next(crc_fcs_next)
	);

endmodule

//--- eth_arp_gmii.sv
// ARP responder top
`timescale 1ns/1ps

module eth_arp_gmii (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic gmii_rxdv,
	input logic [7:0] gmii_rxdata,
	input logic gmii_txbusy,
	output logic gmii_txen,
	output logic [7:0] gmii_txdata,
	output logic pc_refresh,
	output eth_arp_pkg::mac_addr_t pc_mac_addr,
	output eth_arp_pkg::ip_addr_t pc_ip_addr
);

	import eth_arp_pkg::*;

	gmii_rx_t rx;
	arp_peer_t peer;
	logic peer_refresh;

	assign rx = '{dv: gmii_rxdv, data: gmii_rxdata};

	arp_rx_parser u_rx (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.rx(rx),
		.peer(peer),
		.peer_refresh(peer_refresh)
	);

	arp_tx_framer u_tx (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.peer(peer),
		.peer_refresh(peer_refresh),
		.gmii_txbusy(gmii_txbusy),
		.gmii_txen(gmii_txen),
		.gmii_txdata(gmii_txdata)
	);

	assign pc_refresh = peer_refresh;
	assign pc_mac_addr = peer.mac; // last accepted requester
	assign pc_ip_addr = peer.ip;

endmodule

//--- eth_arp_tb_frames.svh
// testbench frame helpers
`ifndef ETH_ARP_TB_FRAMES_SVH
`define ETH_ARP_TB_FRAMES_SVH

logic [31:0] lcg_state = 32'h58dc_c9a6;
logic [31:0] crc_run;
logic [7:0] frame_q[$]; // frame under construction

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// msb-first CRC-32, wire bits enter lsb first
function automatic logic [31:0] crc_add(input logic [31:0] c, input logic [7:0] b);
	logic fb;
	for (int i = 0; i < 8; i++) begin
		fb = c[31] ^ b[i];
		c = {c[30:0], 1'b0};
		if (fb) begin
			c = c ^ 32'h04C1_1DB7;
		end
	end
	return c;
endfunction

function automatic logic [31:0] bit_reverse(input logic [31:0] v);
	logic [31:0] r;
	for (int i = 0; i < 32; i++) begin
		r[i] = v[31 - i];
	end
	return r;
endfunction

// append n bytes of w, most significant first
task automatic put_word(input logic [47:0] w, input int n);
	for (int i = n - 1; i >= 0; i--) begin
		frame_q.push_back(w[8 * i +: 8]);
		crc_run = crc_add(crc_run, w[8 * i +: 8]);
	end
endtask

task automatic build_frame(input eth_arp_pkg::mac_addr_t dst, input eth_arp_pkg::mac_addr_t src,
		input logic [15:0] etype, input logic [15:0] op, input eth_arp_pkg::mac_addr_t smac,
		input eth_arp_pkg::ip_addr_t sip, input eth_arp_pkg::mac_addr_t tmac,
		input eth_arp_pkg::ip_addr_t tip);
	logic [31:0] fcs;
	frame_q.delete();
	for (int i = 0; i < `PREAMBLE_LEN; i++) begin
		frame_q.push_back(`PREAMBLE_BYTE);
	end
	frame_q.push_back(`SFD_BYTE);
	crc_run = 32'hFFFF_FFFF;
	put_word(dst, 6);
	put_word(src, 6);
	put_word(etype, 2);
	put_word(`ARP_HDR_IPV4, 6);
	put_word(op, 2);
	put_word(smac, 6);
	put_word(sip, 4);
	put_word(tmac, 6);
	put_word(tip, 4);
	for (int i = 0; i < `ARP_FILL_LEN; i++) begin
		put_word(48'h0, 1);
	end
	fcs = ~bit_reverse(crc_run);
	for (int i = 0; i < 4; i++) begin
		frame_q.push_back(fcs[8 * i +: 8]); // lsb first
	end
endtask

`endif

//--- eth_arp_tb.sv
// ARP responder testbench
`timescale 1ns/1ps
`include "eth_arp_settings.svh"

module eth_arp_tb;

	localparam int CLK_PERIOD = 8;
	localparam int N_FRAMES = 13;

	logic sys_clk;
	logic sys_rst_n;
	logic gmii_rxdv;
	logic [7:0] gmii_rxdata;
	logic gmii_txbusy;
	logic gmii_txen;
	logic [7:0] gmii_txdata;
	logic pc_refresh;
	eth_arp_pkg::mac_addr_t pc_mac_addr;
	eth_arp_pkg::ip_addr_t pc_ip_addr;

	logic rx_last = 1'b0; // marks the last byte of a sent frame
	logic expect_ok = 1'b0;
	logic random_on = 1'b0;
	logic [7:0] model_q[$];
	logic [7:0] tx_q[$];
	eth_arp_pkg::mac_addr_t exp_mac = '0;
	eth_arp_pkg::ip_addr_t exp_ip = '0;
	int data_errs = 0;
	int timing_errs = 0;
	int frames_done = 0;

	`include "eth_arp_tb_frames.svh"

	eth_arp_gmii dut (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.gmii_rxdv(gmii_rxdv),
		.gmii_rxdata(gmii_rxdata),
		.gmii_txbusy(gmii_txbusy),
		.gmii_txen(gmii_txen),
		.gmii_txdata(gmii_txdata),
		.pc_refresh(pc_refresh),
		.pc_mac_addr(pc_mac_addr),
		.pc_ip_addr(pc_ip_addr)
	);

	initial begin
		sys_clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) sys_clk = ~sys_clk;
		end
	end

	always @(posedge sys_clk) begin
		if (sys_rst_n && gmii_txen && !gmii_txbusy) begin
			tx_q.push_back(gmii_txdata); // accepted beat
		end
	end

	// back-pressure only while a reply is on the wire
	initial begin
		logic [31:0] r;
		gmii_txbusy = 1'b0;
		forever begin
			@(negedge sys_clk);
			if (random_on && gmii_txen) begin
				r = lcg_next();
				gmii_txbusy = (r[31:30] == 2'b00);
			end else begin
				gmii_txbusy = 1'b0;
			end
		end
	end

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		pc_refresh == $past(rx_last && expect_ok, 3))
	else begin
		timing_errs++;
		$display("** Error: [%0t] pc_refresh is %b against the frame end", $time, pc_refresh);
	end

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(gmii_txen && gmii_txbusy) |=> (gmii_txen && $stable(gmii_txdata)))
	else begin
		data_errs++;
		$display("** Error: [%0t] gmii_txdata moved while gmii_txbusy was high", $time);
	end

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(gmii_txen) |-> ($past(pc_refresh) && gmii_txdata == `PREAMBLE_BYTE))
	else begin
		timing_errs++;
		$display("** Error: [%0t] gmii_txen rose without a refresh one edge before", $time);
	end

	task automatic check_reset_state();
		assert (!gmii_txen && !pc_refresh && gmii_txdata == 8'h00 && pc_mac_addr == '0
				&& pc_ip_addr == '0)
		else begin
			data_errs++;
			$display("** Error: [%0t] outputs are not at their reset values", $time);
		end
	endtask

	task automatic send_frame();
		logic [31:0] r;
		for (int i = 0; i < frame_q.size(); i++) begin
			r = lcg_next();
			if (random_on && r[31:30] == 2'b00) begin
				@(negedge sys_clk);
				gmii_rxdv = 1'b0; // receive gap
				rx_last = 1'b0;
			end
			@(negedge sys_clk);
			gmii_rxdv = 1'b1;
			gmii_rxdata = frame_q[i];
			rx_last = (i == frame_q.size() - 1);
		end
		@(negedge sys_clk);
		gmii_rxdv = 1'b0;
		gmii_rxdata = 8'h00;
		rx_last = 1'b0;
	endtask

	task automatic run_request(input eth_arp_pkg::mac_addr_t dst,
			input eth_arp_pkg::mac_addr_t pmac, input eth_arp_pkg::ip_addr_t pip,
			input eth_arp_pkg::ip_addr_t tip, input logic [15:0] op, input logic [15:0] etype,
			input bit corrupt, input bit ok);
		int waited;
		int txen_cycles;
		build_frame(pmac, `BOARD_MAC_ADDR, `ETH_TYPE_ARP, `ARP_OP_REPLY, `BOARD_MAC_ADDR,
			`BOARD_IP_ADDR, pmac, pip);
		model_q = frame_q;
		// sender MAC differs so only the ethernet source can name the peer
		build_frame(dst, pmac, etype, op, ~pmac, pip, 48'h0, tip);
		if (corrupt) begin
			frame_q[frame_q.size() - 1] ^= 8'h5A; // last FCS byte
		end
		tx_q.delete();
		expect_ok = ok;
		send_frame();
		waited = 0;
		txen_cycles = 0;
		if (ok) begin
			while (!gmii_txen && waited < 300) begin
				@(negedge sys_clk);
				waited++;
			end
			while (gmii_txen && waited < 300) begin
				@(negedge sys_clk);
				waited++;
				txen_cycles++;
			end
			if (waited >= 300) begin
				timing_errs++;
				$display("reply to peer %h did not finish within 300 cycles", pmac);
			end
			if (!random_on) begin
				assert (txen_cycles == 72) else begin
					timing_errs++;
					$display("** Error: [%0t] reply took %0d cycles", $time, txen_cycles);
				end
			end
			assert (tx_q.size() == model_q.size()) else begin
				data_errs++;
				$display("** Error: [%0t] reply has %0d bytes", $time, tx_q.size());
			end
			for (int i = 0; i < tx_q.size() && i < model_q.size(); i++) begin
				assert (tx_q[i] == model_q[i]) else begin
					data_errs++;
					$display("** Error: [%0t] reply byte %0d is %h, expected %h", $time, i,
						tx_q[i], model_q[i]);
				end
			end
			exp_mac = pmac;
			exp_ip = pip;
		end else begin
			repeat (40) @(negedge sys_clk);
			assert (tx_q.size() == 0) else begin
				data_errs++;
				$display("** Error: [%0t] %0d bytes sent for a rejected frame", $time,
					tx_q.size());
			end
		end
		assert (pc_mac_addr == exp_mac && pc_ip_addr == exp_ip) else begin
			data_errs++;
			$display("** Error: [%0t] peer is %h/%h, expected %h/%h", $time, pc_mac_addr,
				pc_ip_addr, exp_mac, exp_ip);
		end
		frames_done++;
	endtask

	initial begin
		eth_arp_pkg::mac_addr_t dst;
		logic [31:0] r1;
		logic [31:0] r2;
		sys_rst_n = 1'b0;
		gmii_rxdv = 1'b0;
		gmii_rxdata = 8'h00;
		repeat (2) @(negedge sys_clk);
		check_reset_state();
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		check_reset_state();
		run_request(48'hFFFF_FFFF_FFFF, 48'h0A_1B_2C_3D_4E_5F, 32'hA9FE_0142, `BOARD_IP_ADDR,
			`ARP_OP_REQUEST, `ETH_TYPE_ARP, 1'b0, 1'b1);
		run_request(`BOARD_MAC_ADDR, 48'h02_60_8C_12_34_56, 32'hA9FE_0A0B, `BOARD_IP_ADDR,
			`ARP_OP_REQUEST, `ETH_TYPE_ARP, 1'b0, 1'b1);
		// rejected frames leave the peer alone
		run_request(48'h00_11_22_33_44_66, 48'h0C_0D_0E_0F_10_11, 32'hA9FE_0203, `BOARD_IP_ADDR,
			`ARP_OP_REQUEST, `ETH_TYPE_ARP, 1'b0, 1'b0);
		run_request(48'hFFFF_FFFF_FFFF, 48'h0C_0D_0E_0F_10_11, 32'hA9FE_0203,
			`BOARD_IP_ADDR + 32'd1, `ARP_OP_REQUEST, `ETH_TYPE_ARP, 1'b0, 1'b0);
		run_request(48'hFFFF_FFFF_FFFF, 48'h0C_0D_0E_0F_10_11, 32'hA9FE_0203, `BOARD_IP_ADDR,
			`ARP_OP_REPLY, `ETH_TYPE_ARP, 1'b0, 1'b0);
		run_request(48'hFFFF_FFFF_FFFF, 48'h0C_0D_0E_0F_10_11, 32'hA9FE_0203, `BOARD_IP_ADDR,
			`ARP_OP_REQUEST, 16'h0800, 1'b0, 1'b0);
		run_request(48'hFFFF_FFFF_FFFF, 48'h0C_0D_0E_0F_10_11, 32'hA9FE_0203, `BOARD_IP_ADDR,
			`ARP_OP_REQUEST, `ETH_TYPE_ARP, 1'b1, 1'b0);
		random_on = 1'b1;
		for (int k = 0; k < 6; k++) begin
			r1 = lcg_next();
			r2 = lcg_next();
			dst = r1[31] ? 48'hFFFF_FFFF_FFFF : `BOARD_MAC_ADDR;
			run_request(dst, {r1[23:0], r2[23:0]}, lcg_next(), `BOARD_IP_ADDR,
				`ARP_OP_REQUEST, `ETH_TYPE_ARP, 1'b0, 1'b1);
		end
		$display("checks done, %0d data errors, %0d timing errors", data_errs, timing_errs);
		if (data_errs + timing_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// about 200 cycles per frame covers gaps and back-pressure
	initial begin
		#(N_FRAMES * 200 * CLK_PERIOD);
		$display("watchdog expired with %0d of %0d frames finished", frames_done, N_FRAMES);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- eth_arp.f
+incdir+.
eth_arp_pkg.sv
crc32_d8.sv
arp_rx_parser.sv
arp_tx_framer.sv
eth_arp_gmii.sv
eth_arp_tb.sv

//--- Bender.yml
package:
  name: eth_arp

sources:
  - include_dirs:
      - .
    files:
      - eth_arp_pkg.sv
      - crc32_d8.sv
      - arp_rx_parser.sv
      - arp_tx_framer.sv
      - eth_arp_gmii.sv
  - target: test
    include_dirs:
      - .
    files:
      - eth_arp_tb.sv
